// File: rtl/rd_tlp_pkg.sv
package rd_tlp_pkg;

    // ============================================================
    // Sizes of the read channel
    // ============================================================

    // PCIe tag space shared by reads and write fences
    localparam int NUM_RD_TAGS = 32;
    // The lowest tags belong to the write fence pipeline
    localparam int NUM_FENCE_TAGS = 4;
    // A line is 16 bytes, so four dwords
    localparam int LINE_DWORDS = 4;
    // Largest AFU request in lines
    localparam int MAX_LINES = 4;

    // ============================================================
    // Vector types
    // ============================================================

    typedef logic [63:0] t_addr;
    typedef logic [7:0] t_afu_tag;
    typedef logic [$clog2(NUM_RD_TAGS)-1:0] t_dma_rd_tag;
    // Holds 1 to MAX_LINES, so one bit wider than an index
    typedef logic [$clog2(MAX_LINES+1)-1:0] t_line_count;
    typedef logic [$clog2(MAX_LINES)-1:0] t_line_idx;
    typedef logic [9:0] t_dw_len;
    typedef logic [11:0] t_byte_count;
    typedef logic [LINE_DWORDS*32-1:0] t_line_data;

    // ============================================================
    // Length conversions
    // ============================================================

    // TLP length field for a request of n lines
    function automatic t_dw_len line_count_to_dw_len(input t_line_count n);
        return t_dw_len'(n) * t_dw_len'(LINE_DWORDS);
    endfunction

    // Whole lines covered by a dword count
    function automatic t_line_count dw_len_to_line_count(input t_dw_len dw);
        return t_line_count'(dw / t_dw_len'(LINE_DWORDS));
    endfunction

endpackage

// File: rtl/req_fifo2.sv
module req_fifo2
    import rd_tlp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    input  logic        enq_valid,
    output logic        enq_ready,
    input  logic        enq_is_addr64,
    input  t_addr       enq_addr,
    input  t_line_count enq_line_count,
    input  t_afu_tag    enq_afu_tag,

    output logic        head_valid,
    input  logic        head_deq,
    output logic        head_is_addr64,
    output t_addr       head_addr,
    output t_line_count head_line_count,
    output t_afu_tag    head_afu_tag
);

    // One queue entry holds the address flag and all request fields
    typedef logic [$bits(t_addr)+$bits(t_line_count)+$bits(t_afu_tag):0] t_entry;

    t_entry enq_data;
    t_entry slot [2];
    logic [1:0] slot_valid;
    logic enq;

    // Slot 0 is always the head, slot 1 only fills behind it
    assign enq_ready = !slot_valid[1];
    assign enq = enq_valid && enq_ready;
    assign enq_data = {enq_is_addr64, enq_addr, enq_line_count, enq_afu_tag};

    assign head_valid = slot_valid[0];
    assign {head_is_addr64, head_addr, head_line_count, head_afu_tag} = slot[0];

    always_ff @(posedge clk)
    begin
        if (head_deq)
        begin
            // Move the waiting entry up, or refill the head from the input
            if (slot_valid[1])
            begin
                slot[0] <= slot[1];
                slot_valid[1] <= 1'b0;
            end
            else
            begin
                slot[0] <= enq_data;
                slot_valid[0] <= enq;
            end
        end
        else if (enq)
        begin
            if (!slot_valid[0])
            begin
                slot[0] <= enq_data;
                slot_valid[0] <= 1'b1;
            end
            else
            begin
                slot[1] <= enq_data;
                slot_valid[1] <= 1'b1;
            end
        end

        if (!reset_n)
        begin
            slot_valid <= '0;
        end
    end

    // The generator may only take the head when one is there
    deq_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
        head_deq |-> head_valid)
        else $error("Dequeue from an empty request FIFO");

endmodule

// File: rtl/tag_pool.sv
module tag_pool
    import rd_tlp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    input  logic        alloc,
    output logic        alloc_ready,
    output t_dma_rd_tag alloc_tag,

    input  logic        free,
    input  t_dma_rd_tag free_tag
);

    // One bit per tag, set while a read with that tag is outstanding
    logic [NUM_RD_TAGS-1:0] busy;

    // ============================================================
    // Lowest free read tag
    // ============================================================

    // The search runs from the top down so that the last hit is the
    // lowest free tag. It stops above the fence range, so reserved
    // tags never come out of the pool
    always_comb
    begin
        alloc_ready = 1'b0;
        alloc_tag = '0;
        for (int i = NUM_RD_TAGS - 1; i >= NUM_FENCE_TAGS; i--)
        begin
            if (!busy[i])
            begin
                alloc_ready = 1'b1;
                alloc_tag = t_dma_rd_tag'(i);
            end
        end
    end

    // ============================================================
    // Busy bits
    // ============================================================

    // A freed tag is visible to the search in the very next cycle.
    // Alloc and free never hit the same tag, since alloc only picks
    // idle tags and free only releases busy ones
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            busy[alloc_tag] <= 1'b1;
        end

        if (free)
        begin
            busy[free_tag] <= 1'b0;
        end

        if (!reset_n)
        begin
            busy <= '0;
        end
    end

    // The completion side must only release tags that were handed out
    free_idle_tag: assert property (@(posedge clk) disable iff (!reset_n)
        free |-> busy[free_tag])
        else $error("Freeing idle read tag %0d", free_tag);

    // The generator must wait for a tag before it dequeues
    alloc_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
        alloc |-> alloc_ready)
        else $error("Tag allocation with no free read tag");

endmodule

// File: rtl/rd_meta_ram.sv
module rd_meta_ram
    import rd_tlp_pkg::*;
(
    input  logic        clk,

    input  logic        wen,
    input  t_dma_rd_tag waddr,
    input  t_afu_tag    wafu_tag,
    input  t_line_count wline_count,

    input  t_dma_rd_tag raddr,
    output t_afu_tag    rafu_tag,
    output t_line_count rline_count
);

    // Per-tag record of the original request, small enough for LUT RAM
    t_afu_tag afu_tag_mem [NUM_RD_TAGS];
    t_line_count line_count_mem [NUM_RD_TAGS];

    // Written when the generator issues the request header
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            afu_tag_mem[waddr] <= wafu_tag;
            line_count_mem[waddr] <= wline_count;
        end
    end

    // The router needs the record in the same cycle as the completion
    // header, so the read port has no register
    assign rafu_tag = afu_tag_mem[raddr];
    assign rline_count = line_count_mem[raddr];

endmodule

// File: rtl/rd_req_tlp_gen.sv
module rd_req_tlp_gen
    import rd_tlp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // Head of the request FIFO
    input  logic        head_valid,
    output logic        head_deq,
    input  logic        head_is_addr64,
    input  t_addr       head_addr,
    input  t_line_count head_line_count,
    input  t_afu_tag    head_afu_tag,

    // Tag pool
    output logic        alloc,
    input  logic        alloc_ready,
    input  t_dma_rd_tag alloc_tag,

    // Metadata write port
    output logic        meta_wen,
    output t_dma_rd_tag meta_waddr,
    output t_afu_tag    meta_wafu_tag,
    output t_line_count meta_wline_count,

    // Memory read header stream
    output logic        tlp_valid,
    input  logic        tlp_ready,
    output logic        tlp_is_addr64,
    output t_addr       tlp_addr,
    output t_dw_len     tlp_len_dw,
    output t_dma_rd_tag tlp_tag
);

    // Output register can take a new header this cycle
    logic tlp_load;

    assign tlp_load = tlp_ready || !tlp_valid;

    // ============================================================
    // Dequeue and tag allocation
    // ============================================================

    // A request leaves the FIFO only when it has a tag and somewhere to go
    assign head_deq = head_valid && alloc_ready && tlp_load;
    assign alloc = head_deq;

    // Record the AFU tag and size under the new PCIe tag
    assign meta_wen = head_deq;
    assign meta_waddr = alloc_tag;
    assign meta_wafu_tag = head_afu_tag;
    assign meta_wline_count = head_line_count;

    // ============================================================
    // Header register
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (tlp_load)
        begin
            tlp_valid <= head_deq;
            tlp_is_addr64 <= head_is_addr64;

            // MRd32 carries only the low address dword
            if (head_is_addr64)
            begin
                tlp_addr <= head_addr;
            end
            else
            begin
                tlp_addr <= {32'b0, head_addr[31:0]};
            end

            tlp_len_dw <= line_count_to_dw_len(head_line_count);
            tlp_tag <= alloc_tag;
        end

        if (!reset_n)
        begin
            tlp_valid <= 1'b0;
        end
    end

    // A stalled header must not change under the host
    tlp_hold: assert property (@(posedge clk) disable iff (!reset_n)
        tlp_valid && !tlp_ready |=> tlp_valid && $stable(tlp_is_addr64) &&
            $stable(tlp_addr) && $stable(tlp_len_dw) && $stable(tlp_tag))
        else $error("TLP header changed while stalled");

endmodule

// File: rtl/rd_cpl_router.sv
module rd_cpl_router
    import rd_tlp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // Completion beats from the host
    input  logic        cpl_valid,
    output logic        cpl_ready,
    input  logic        cpl_sop,
    input  logic        cpl_eop,
    input  logic        cpl_has_data,
    input  t_dma_rd_tag cpl_tag,
    input  t_dw_len     cpl_len_dw,
    input  t_byte_count cpl_byte_count,
    input  t_line_data  cpl_data,

    // Write fence completions
    output logic        fence_valid,
    input  logic        fence_ready,
    output t_dma_rd_tag fence_tag,

    // AFU read responses
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output t_afu_tag    rsp_afu_tag,
    output t_line_idx   rsp_line_idx,
    output logic        rsp_last,
    output t_line_data  rsp_data,

    // Metadata lookup
    output t_dma_rd_tag meta_raddr,
    input  t_afu_tag    meta_afu_tag,
    input  t_line_count meta_line_count,

    // Tag release
    output logic        free,
    output t_dma_rd_tag free_tag
);

    logic rsp_load;
    logic is_fence;
    t_dw_len remain_dw;

    // Beat decode, valid in the SOP cycle and in later beats
    logic cur_active;
    logic cur_last;
    t_afu_tag cur_afu_tag;
    t_line_idx cur_line_idx;

    // State saved from the previous beat of the packet
    logic reg_active;
    logic reg_last;
    t_afu_tag reg_afu_tag;
    t_line_idx reg_line_idx;
    t_dma_rd_tag reg_cpl_tag;

    // ============================================================
    // Flow control and fence forwarding
    // ============================================================

    assign rsp_load = !rsp_valid || rsp_ready;
    assign cpl_ready = rsp_load && fence_ready;

    assign meta_raddr = cpl_tag;
    assign is_fence = cpl_tag < t_dma_rd_tag'(NUM_FENCE_TAGS);
    // Byte count is the remainder of the whole read, in dwords here
    assign remain_dw = cpl_byte_count[11:2];

    // Fences pass straight through to the write side
    assign fence_valid = cpl_valid && cpl_ready && cpl_sop && is_fence;
    assign fence_tag = cpl_tag;

    // ============================================================
    // Beat decode
    // ============================================================

    always_comb
    begin
        if (cpl_sop)
        begin
            cur_active = cpl_has_data && !is_fence;
            // Last packet of the read when it covers everything that is left
            cur_last = (remain_dw == cpl_len_dw);
            cur_afu_tag = meta_afu_tag;
            // Lines already delivered by earlier packets of a split read
            cur_line_idx = t_line_idx'(meta_line_count - dw_len_to_line_count(remain_dw));
        end
        else
        begin
            cur_active = reg_active;
            cur_last = reg_last;
            cur_afu_tag = reg_afu_tag;
            cur_line_idx = reg_line_idx + 1'b1;
        end

        // A packet may pause between beats
        if (!cpl_valid)
        begin
            cur_active = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cpl_valid && cpl_ready)
        begin
            reg_active <= cur_active && !cpl_eop;
            reg_last <= cur_last;
            reg_afu_tag <= cur_afu_tag;
            reg_line_idx <= cur_line_idx;

            if (cpl_sop)
            begin
                reg_cpl_tag <= cpl_tag;
            end
        end

        if (!reset_n)
        begin
            reg_active <= 1'b0;
        end
    end

    // ============================================================
    // Response register and tag release
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (rsp_load)
        begin
            rsp_valid <= cur_active && fence_ready;
            rsp_afu_tag <= cur_afu_tag;
            rsp_line_idx <= cur_line_idx;
            rsp_last <= cur_last && cpl_eop;
            rsp_data <= cpl_data;
        end

        if (!reset_n)
        begin
            rsp_valid <= 1'b0;
        end
    end

    // No new packet is taken while the last beat waits, so the saved tag still matches
    assign free = rsp_valid && rsp_ready && rsp_last;
    assign free_tag = reg_cpl_tag;

    sop_in_packet: assert property (@(posedge clk) disable iff (!reset_n)
        cpl_valid && cpl_sop |-> !reg_active)
        else $error("Completion SOP inside an active read response");

    // A dataless completion on a read tag would leak the tag
    read_without_data: assert property (@(posedge clk) disable iff (!reset_n)
        cpl_valid && cpl_ready && cpl_sop && !is_fence |-> cpl_has_data)
        else $error("Completion without data on read tag %0d", cpl_tag);

endmodule

// File: rtl/host_rd_chan.sv
module host_rd_chan
    import rd_tlp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // AFU read requests
    input  logic        req_valid,
    output logic        req_ready,
    input  t_addr       req_addr,
    input  t_line_count req_line_count,
    input  t_afu_tag    req_afu_tag,

    // Memory read headers to the host
    output logic        tlp_valid,
    input  logic        tlp_ready,
    output logic        tlp_is_addr64,
    output t_addr       tlp_addr,
    output t_dw_len     tlp_len_dw,
    output t_dma_rd_tag tlp_tag,

    // Completions from the host
    input  logic        cpl_valid,
    output logic        cpl_ready,
    input  logic        cpl_sop,
    input  logic        cpl_eop,
    input  logic        cpl_has_data,
    input  t_dma_rd_tag cpl_tag,
    input  t_dw_len     cpl_len_dw,
    input  t_byte_count cpl_byte_count,
    input  t_line_data  cpl_data,

    // Fence completions and AFU responses
    output logic        fence_valid,
    input  logic        fence_ready,
    output t_dma_rd_tag fence_tag,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output t_afu_tag    rsp_afu_tag,
    output t_line_idx   rsp_line_idx,
    output logic        rsp_last,
    output t_line_data  rsp_data,

    // Hint for read/write arbitration, one cycle behind the pool
    output logic        tag_available
);

    logic enq_is_addr64;
    logic head_valid;
    logic head_deq;
    logic head_is_addr64;
    t_addr head_addr;
    t_line_count head_line_count;
    t_afu_tag head_afu_tag;

    logic alloc;
    logic alloc_ready;
    t_dma_rd_tag alloc_tag;
    logic free;
    t_dma_rd_tag free_tag;

    logic meta_wen;
    t_dma_rd_tag meta_waddr;
    t_afu_tag meta_wafu_tag;
    t_line_count meta_wline_count;
    t_dma_rd_tag meta_raddr;
    t_afu_tag meta_afu_tag;
    t_line_count meta_line_count;

    // ============================================================
    // Request queue
    // ============================================================

    // PCIe forbids MRd64 for addresses below 4 GiB, so decide it early
    assign enq_is_addr64 = |req_addr[63:32];

    req_fifo2 u_req_fifo (
        .clk,
        .reset_n,
        .enq_valid(req_valid),
        .enq_ready(req_ready),
        .enq_is_addr64,
        .enq_addr(req_addr),
        .enq_line_count(req_line_count),
        .enq_afu_tag(req_afu_tag),
        .head_valid,
        .head_deq,
        .head_is_addr64,
        .head_addr,
        .head_line_count,
        .head_afu_tag
    );

    // ============================================================
    // Tags and metadata
    // ============================================================

    tag_pool u_tag_pool (
        .clk,
        .reset_n,
        .alloc,
        .alloc_ready,
        .alloc_tag,
        .free,
        .free_tag
    );

    always_ff @(posedge clk)
    begin
        tag_available <= alloc_ready;
        if (!reset_n)
        begin
            tag_available <= 1'b1;
        end
    end

    rd_meta_ram u_meta (
        .clk,
        .wen(meta_wen),
        .waddr(meta_waddr),
        .wafu_tag(meta_wafu_tag),
        .wline_count(meta_wline_count),
        .raddr(meta_raddr),
        .rafu_tag(meta_afu_tag),
        .rline_count(meta_line_count)
    );

    // ============================================================
    // Header generation and completion routing
    // ============================================================

    rd_req_tlp_gen u_tlp_gen (
        .clk,
        .reset_n,
        .head_valid,
        .head_deq,
        .head_is_addr64,
        .head_addr,
        .head_line_count,
        .head_afu_tag,
        .alloc,
        .alloc_ready,
        .alloc_tag,
        .meta_wen,
        .meta_waddr,
        .meta_wafu_tag,
        .meta_wline_count,
        .tlp_valid,
        .tlp_ready,
        .tlp_is_addr64,
        .tlp_addr,
        .tlp_len_dw,
        .tlp_tag
    );

    rd_cpl_router u_cpl_router (
        .clk,
        .reset_n,
        .cpl_valid,
        .cpl_ready,
        .cpl_sop,
        .cpl_eop,
        .cpl_has_data,
        .cpl_tag,
        .cpl_len_dw,
        .cpl_byte_count,
        .cpl_data,
        .fence_valid,
        .fence_ready,
        .fence_tag,
        .rsp_valid,
        .rsp_ready,
        .rsp_afu_tag,
        .rsp_line_idx,
        .rsp_last,
        .rsp_data,
        .meta_raddr,
        .meta_afu_tag,
        .meta_line_count,
        .free,
        .free_tag
    );

endmodule

// File: verification/host_rd_chan_tasks.svh
// ============================================================
// Checking and stream helpers
// ============================================================

// Every task starts and returns just after a rising edge, so values read
// there are the ones the DUT saw at that edge
task automatic check(input string name, input logic [127:0] actual,
                     input logic [127:0] expected);
    if (actual !== expected)
    begin
        $display("FAILED %s: got %0h, expected %0h", name, actual, expected);
        $display("Checks failed");
        $fatal(1);
    end
endtask

// Fresh random payload for the next completions
task automatic fill_payload();
    for (int i = 0; i < PAY_LINES; i++)
    begin
        pay[i] = {$urandom, $urandom, $urandom, $urandom};
    end
endtask

// Hands one request to the FIFO and returns at the accepting edge
task automatic push_req(input t_addr addr, input int lines, input t_afu_tag afu_tag);
    req_valid <= 1'b1;
    req_addr <= addr;
    req_line_count <= t_line_count'(lines);
    req_afu_tag <= afu_tag;
    @(posedge clk);
    while (!req_ready)
        @(posedge clk);
    req_valid <= 1'b0;
endtask

// Waits for the next header transfer and checks it against the request
task automatic wait_header(input t_addr addr, input int lines, output t_dma_rd_tag tag);
    @(posedge clk);
    while (!(tlp_valid && tlp_ready))
        @(posedge clk);
    // MRd64 only when the upper dword is in use
    check("tlp_is_addr64", 128'(tlp_is_addr64), 128'(addr[63:32] != 32'h0));
    // Below 4 GiB the low dword is the whole address
    check("tlp_addr", 128'(tlp_addr), 128'(addr));
    check("tlp_len_dw", 128'(tlp_len_dw), 128'(lines * LINE_DWORDS));
    check("tlp_tag_is_read_tag", 128'(int'(tlp_tag) >= NUM_FENCE_TAGS), 128'(1));
    tag = tlp_tag;
endtask

task automatic issue_read(input t_addr addr, input int lines, input t_afu_tag afu_tag,
                          output t_dma_rd_tag tag);
    push_req(addr, lines, afu_tag);
    wait_header(addr, lines, tag);
endtask

// One completion packet, one line per beat, starting at pay[base]
task automatic send_cpl(input t_dma_rd_tag tag, input int lines, input int byte_count,
                        input int base);
    for (int i = 0; i < lines; i++)
    begin
        cpl_valid <= 1'b1;
        cpl_sop <= (i == 0);
        cpl_eop <= (i == lines - 1);
        cpl_has_data <= 1'b1;
        cpl_tag <= tag;
        cpl_len_dw <= t_dw_len'(lines * LINE_DWORDS);
        cpl_byte_count <= t_byte_count'(byte_count);
        cpl_data <= pay[base + i];
        @(posedge clk);
        while (!cpl_ready)
            @(posedge clk);
    end
    cpl_valid <= 1'b0;
endtask

// Collects all responses of one read, last flag only on the final line
task automatic expect_rsps(input t_afu_tag afu_tag, input int lines);
    for (int i = 0; i < lines; i++)
    begin
        @(posedge clk);
        while (!(rsp_valid && rsp_ready))
            @(posedge clk);
        check("rsp_afu_tag", 128'(rsp_afu_tag), 128'(afu_tag));
        check("rsp_line_idx", 128'(rsp_line_idx), 128'(i));
        check("rsp_last", 128'(rsp_last), 128'(i == lines - 1));
        check("rsp_data", 128'(rsp_data), 128'(pay[i]));
    end
endtask

// A single completion covering the whole read, which also frees its tag
task automatic complete_read(input t_dma_rd_tag tag, input t_afu_tag afu_tag,
                             input int lines);
    fork
        send_cpl(tag, lines, lines * LINE_DWORDS * 4, 0);
        expect_rsps(afu_tag, lines);
    join
endtask

// ============================================================
// Directed tests
// ============================================================

task automatic test_reset_values();
    check("tlp_valid", 128'(tlp_valid), 128'(0));
    check("rsp_valid", 128'(rsp_valid), 128'(0));
    check("fence_valid", 128'(fence_valid), 128'(0));
    check("tag_available", 128'(tag_available), 128'(1));
endtask

task automatic test_header();
    t_addr addr64;
    t_addr addr32;
    t_dma_rd_tag tag64;
    t_dma_rd_tag tag32;
    // Bit 32 forced on so the upper dword is never zero
    addr64 = {$urandom | 32'h1, $urandom};
    addr32 = {32'h0, $urandom};
    issue_read(addr64, 2, 8'h11, tag64);
    issue_read(addr32, 1, 8'h22, tag32);
    fill_payload();
    complete_read(tag64, 8'h11, 2);
    complete_read(tag32, 8'h22, 1);
endtask

task automatic test_single_cpl();
    t_dma_rd_tag tag;
    issue_read({32'h0, $urandom}, 3, 8'h5a, tag);
    fill_payload();
    complete_read(tag, 8'h5a, 3);
endtask

task automatic test_split_cpl();
    t_dma_rd_tag tag;
    issue_read({$urandom | 32'h1, $urandom}, 4, 8'ha7, tag);
    fill_payload();
    fork
        begin
            // Byte count is what is left of the 64-byte read at each packet
            send_cpl(tag, 2, 64, 0);
            send_cpl(tag, 2, 32, 2);
        end
        expect_rsps(8'ha7, 4);
    join
endtask

task automatic test_fence();
    cpl_valid <= 1'b1;
    cpl_sop <= 1'b1;
    cpl_eop <= 1'b1;
    cpl_has_data <= 1'b0;
    cpl_tag <= t_dma_rd_tag'(2);
    cpl_len_dw <= '0;
    cpl_byte_count <= '0;
    cpl_data <= '0;
    fence_ready <= 1'b0;
    // The write side is busy, so the completion must wait
    repeat (3)
    begin
        @(posedge clk);
        check("cpl_ready", 128'(cpl_ready), 128'(0));
        check("fence_valid", 128'(fence_valid), 128'(0));
    end
    fence_ready <= 1'b1;
    @(posedge clk);
    check("cpl_ready", 128'(cpl_ready), 128'(1));
    check("fence_valid", 128'(fence_valid), 128'(1));
    check("fence_tag", 128'(fence_tag), 128'(2));
    cpl_valid <= 1'b0;
    // A fence never shows up as an AFU response
    repeat (3)
    begin
        @(posedge clk);
        check("rsp_valid", 128'(rsp_valid), 128'(0));
    end
endtask

task automatic test_backpressure();
    t_addr addr_a;
    t_addr addr_b;
    t_dma_rd_tag tag_a;
    t_dma_rd_tag tag_b;
    addr_a = {$urandom | 32'h1, $urandom};
    addr_b = {32'h0, $urandom};
    tlp_ready <= 1'b0;
    push_req(addr_a, 2, 8'h33);
    // The second request waits in the FIFO behind the stalled header
    push_req(addr_b, 1, 8'h34);
    @(posedge clk);
    while (!tlp_valid)
        @(posedge clk);
    repeat (5)
    begin
        @(posedge clk);
        check("tlp_valid", 128'(tlp_valid), 128'(1));
        check("tlp_is_addr64", 128'(tlp_is_addr64), 128'(1));
        check("tlp_addr", 128'(tlp_addr), 128'(addr_a));
        check("tlp_len_dw", 128'(tlp_len_dw), 128'(2 * LINE_DWORDS));
    end
    tlp_ready <= 1'b1;
    wait_header(addr_a, 2, tag_a);
    wait_header(addr_b, 1, tag_b);

    fill_payload();
    rsp_ready <= 1'b0;
    fork
        send_cpl(tag_a, 2, 2 * LINE_DWORDS * 4, 0);
        begin
            @(posedge clk);
            while (!rsp_valid)
                @(posedge clk);
            // First line is held and the second beat is refused meanwhile
            repeat (4)
            begin
                @(posedge clk);
                check("rsp_valid", 128'(rsp_valid), 128'(1));
                check("rsp_afu_tag", 128'(rsp_afu_tag), 128'(8'h33));
                check("rsp_line_idx", 128'(rsp_line_idx), 128'(0));
                check("rsp_data", 128'(rsp_data), 128'(pay[0]));
                check("cpl_ready", 128'(cpl_ready), 128'(0));
            end
            rsp_ready <= 1'b1;
            expect_rsps(8'h33, 2);
        end
    join
    complete_read(tag_b, 8'h34, 1);
endtask

task automatic test_tag_exhaustion();
    t_dma_rd_tag tags [NUM_RD_TAGS - NUM_FENCE_TAGS];
    t_dma_rd_tag tag;
    t_addr addr;
    for (int i = 0; i < NUM_RD_TAGS - NUM_FENCE_TAGS; i++)
    begin
        issue_read({32'h0, $urandom}, 1, t_afu_tag'(i), tags[i]);
        // With nothing freed the pool hands out tags in rising order
        check("tlp_tag", 128'(tags[i]), 128'(i + NUM_FENCE_TAGS));
    end
    @(posedge clk);
    check("tag_available", 128'(tag_available), 128'(0));

    addr = {32'h0, $urandom};
    push_req(addr, 1, 8'hee);
    // Another request fills the FIFO behind the stalled head and closes its input
    push_req({32'h0, $urandom}, 1, 8'hef);
    repeat (20)
    begin
        @(posedge clk);
        check("tlp_valid", 128'(tlp_valid), 128'(0));
        check("req_ready", 128'(req_ready), 128'(0));
    end

    // Releasing one read makes its tag the lowest free one
    fill_payload();
    complete_read(tags[9], t_afu_tag'(9), 1);
    wait_header(addr, 1, tag);
    check("tlp_tag", 128'(tag), 128'(tags[9]));
endtask

// File: verification/host_rd_chan_tb.sv
module host_rd_chan_tb
    import rd_tlp_pkg::*;
();

    // ============================================================
    // Run limits
    // ============================================================

    // The whole sequence needs a few hundred cycles, so this leaves ample margin
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int PAY_LINES = 8;

    logic clk;
    logic reset_n;

    // AFU request side
    logic req_valid;
    logic req_ready;
    t_addr req_addr;
    t_line_count req_line_count;
    t_afu_tag req_afu_tag;

    // Header stream towards the host
    logic tlp_valid;
    logic tlp_ready;
    logic tlp_is_addr64;
    t_addr tlp_addr;
    t_dw_len tlp_len_dw;
    t_dma_rd_tag tlp_tag;

    // Completions played by the testbench as the host
    logic cpl_valid;
    logic cpl_ready;
    logic cpl_sop;
    logic cpl_eop;
    logic cpl_has_data;
    t_dma_rd_tag cpl_tag;
    t_dw_len cpl_len_dw;
    t_byte_count cpl_byte_count;
    t_line_data cpl_data;

    // Fence and response outputs
    logic fence_valid;
    logic fence_ready;
    t_dma_rd_tag fence_tag;
    logic rsp_valid;
    logic rsp_ready;
    t_afu_tag rsp_afu_tag;
    t_line_idx rsp_line_idx;
    logic rsp_last;
    t_line_data rsp_data;
    logic tag_available;

    // Payload lines of the completions in flight, indexed by line of the read
    t_line_data pay [PAY_LINES];
    int cycle_count;

    host_rd_chan uut (.*);

    `include "host_rd_chan_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Ends a run that hangs in one of the wait loops
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $fatal(1);
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        void'($urandom(32'heab2));

        reset_n = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_line_count = '0;
        req_afu_tag = '0;
        tlp_ready = 1'b1;
        cpl_valid = 1'b0;
        cpl_sop = 1'b0;
        cpl_eop = 1'b0;
        cpl_has_data = 1'b0;
        cpl_tag = '0;
        cpl_len_dw = '0;
        cpl_byte_count = '0;
        cpl_data = '0;
        fence_ready = 1'b1;
        rsp_ready = 1'b1;

        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        test_reset_values();
        test_header();
        test_single_cpl();
        test_split_cpl();
        test_fence();
        test_backpressure();
        // Leaves reads outstanding, so it runs last
        test_tag_exhaustion();

        $display("All checks passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
rtl/rd_tlp_pkg.sv
rtl/req_fifo2.sv
rtl/tag_pool.sv
rtl/rd_meta_ram.sv
rtl/rd_req_tlp_gen.sv
rtl/rd_cpl_router.sv
rtl/host_rd_chan.sv
verification/host_rd_chan_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the read channel testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -j 0 -f vlog.f \
    --top-module host_rd_chan_tb -Mdir obj_dir -o host_rd_chan_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/host_rd_chan_sim > sim.log 2>&1
cat sim.log

grep -q "All checks passed" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
